//--- hw/rv_exec_pkg.sv
// Shared types and APB address map for the RV32 OP/OP-IMM slice; XLEN fixed at 32
`default_nettype none

package rv_exec_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  // R-type view, used for the OP group
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  // I-type view, used for the OP-IMM group
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
  } rv_instr_t;

  typedef enum logic [3:0] {
    ALU_ADD     = 4'h0,
    ALU_SUB     = 4'h1,
    ALU_SLL     = 4'h2,
    ALU_SLT     = 4'h3,
    ALU_SLTU    = 4'h4,
    ALU_XOR     = 4'h5,
    ALU_SRL     = 4'h6,
    ALU_SRA     = 4'h7,
    ALU_OR      = 4'h8,
    ALU_AND     = 4'h9,
    ALU_ILLEGAL = 4'hf
  } alu_op_e;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam int APB_ADDR_W = 12;

  // Issue register, then one word per architectural register
  localparam logic [APB_ADDR_W-1:0] ADDR_ISSUE    = 12'h000;
  localparam logic [APB_ADDR_W-1:0] ADDR_REG_BASE = 12'h100;

endpackage

`default_nettype wire

//--- hw/rv_apb_port.sv
// APB3 slave with zero wait states; one transfer at a time, REG_COUNT must be a power of two
`timescale 1ns/1ps
`default_nettype none

module rv_apb_port #(
  parameter int REG_COUNT = 32
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   psel,
  input  logic                                   penable,
  input  logic                                   pwrite,
  input  logic [rv_exec_pkg::APB_ADDR_W-1:0]     paddr,
  input  rv_exec_pkg::word_t                     pwdata,
  output rv_exec_pkg::word_t                     prdata,
  output logic                                   pready,
  output logic                                   pslverr,
  output rv_exec_pkg::rv_instr_t                 instr,
  output logic                                   issue,
  input  logic                                   illegal,
  output logic [$clog2(REG_COUNT)-1:0]           dbg_addr,
  input  rv_exec_pkg::word_t                     dbg_data
);

  localparam int IDX_W = $clog2(REG_COUNT);

  logic                                setup;
  logic                                access;
  logic                                is_issue;
  logic                                in_window;
  logic                                xfer_err;
  logic [rv_exec_pkg::APB_ADDR_W-1:0]  reg_off;

  assign setup  = psel & ~penable;
  assign access = psel & penable & pready;

  // Register window decode
  assign reg_off   = paddr - rv_exec_pkg::ADDR_REG_BASE;
  assign in_window = (paddr >= rv_exec_pkg::ADDR_REG_BASE) &&
                     (reg_off[1:0] == 2'b00) &&
                     (reg_off[rv_exec_pkg::APB_ADDR_W-1:2] < REG_COUNT);
  assign dbg_addr  = reg_off[IDX_W+1:2];

  assign is_issue = (paddr == rv_exec_pkg::ADDR_ISSUE);

  // pwdata is stable over both phases, so the decoder verdict is ready at setup
  assign xfer_err = pwrite ? (~is_issue | illegal) : ~in_window;

  assign instr = rv_exec_pkg::rv_instr_t'(pwdata);
  assign issue = access & pwrite & is_issue;

  // Response sampled in setup, presented during access
  always_ff @(posedge clk) begin
    if (rst) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      pready  <= setup;
      pslverr <= setup & xfer_err;
    end
  end

  always_ff @(posedge clk) begin
    prdata <= (setup && !pwrite && in_window) ? dbg_data : '0;
  end

  a_penable_after_psel: assert property (
    @(posedge clk) disable iff (rst) $rose(penable) |-> $past(psel)
  );

endmodule

`default_nettype wire

//--- hw/rv_decoder.sv
// Decodes only OP and OP-IMM; everything else, and any register index >= REG_COUNT, is illegal
`timescale 1ns/1ps
`default_nettype none

module rv_decoder #(
  parameter int REG_COUNT = 32
) (
  input  rv_exec_pkg::rv_instr_t          instr,
  input  logic                            issue,
  output logic [$clog2(REG_COUNT)-1:0]    rs1_addr,
  output logic [$clog2(REG_COUNT)-1:0]    rs2_addr,
  output logic [$clog2(REG_COUNT)-1:0]    rd_addr,
  output rv_exec_pkg::word_t              imm,
  output logic                            use_imm,
  output rv_exec_pkg::alu_op_e            alu_op,
  output logic                            wr_req,
  output logic                            illegal
);

  localparam int IDX_W  = $clog2(REG_COUNT);
  localparam int KEY_W  = 17;
  localparam int PAIR_W = KEY_W + 4;
  localparam int NR_KEY = 19;

  localparam logic [6:0] OP  = rv_exec_pkg::OPC_OP;
  localparam logic [6:0] OPI = rv_exec_pkg::OPC_OP_IMM;

  // Key is {opcode, funct3, funct7}; data is the ALU operation
  localparam logic [PAIR_W-1:0] LUT [NR_KEY] = '{
    {OP,  3'b000, 7'h00, rv_exec_pkg::ALU_ADD},
    {OP,  3'b000, 7'h20, rv_exec_pkg::ALU_SUB},
    {OP,  3'b001, 7'h00, rv_exec_pkg::ALU_SLL},
    {OP,  3'b010, 7'h00, rv_exec_pkg::ALU_SLT},
    {OP,  3'b011, 7'h00, rv_exec_pkg::ALU_SLTU},
    {OP,  3'b100, 7'h00, rv_exec_pkg::ALU_XOR},
    {OP,  3'b101, 7'h00, rv_exec_pkg::ALU_SRL},
    {OP,  3'b101, 7'h20, rv_exec_pkg::ALU_SRA},
    {OP,  3'b110, 7'h00, rv_exec_pkg::ALU_OR},
    {OP,  3'b111, 7'h00, rv_exec_pkg::ALU_AND},
    {OPI, 3'b000, 7'h00, rv_exec_pkg::ALU_ADD},
    {OPI, 3'b010, 7'h00, rv_exec_pkg::ALU_SLT},
    {OPI, 3'b011, 7'h00, rv_exec_pkg::ALU_SLTU},
    {OPI, 3'b100, 7'h00, rv_exec_pkg::ALU_XOR},
    {OPI, 3'b110, 7'h00, rv_exec_pkg::ALU_OR},
    {OPI, 3'b111, 7'h00, rv_exec_pkg::ALU_AND},
    {OPI, 3'b001, 7'h00, rv_exec_pkg::ALU_SLL},
    {OPI, 3'b101, 7'h00, rv_exec_pkg::ALU_SRL},
    {OPI, 3'b101, 7'h20, rv_exec_pkg::ALU_SRA}
  };

  logic [KEY_W-1:0] key;
  logic [6:0]       imm_f7;
  logic [4:0]       rs1_full;
  logic [4:0]       rd_full;
  logic [3:0]       lut_data;
  logic             hit;
  logic             idx_bad;

  assign use_imm = (instr.r.opcode == OPI);

  // Only shift-immediates carry a funct7 in imm12
  assign imm_f7 = (instr.i.funct3 == 3'b001 || instr.i.funct3 == 3'b101) ?
                  instr.i.imm12[11:5] : 7'h00;

  assign key = use_imm ? {instr.i.opcode, instr.i.funct3, imm_f7} :
                         {instr.r.opcode, instr.r.funct3, instr.r.funct7};

  always_comb begin
    lut_data = '0;
    hit      = 1'b0;
    for (int n = 0; n < NR_KEY; n++) begin
      lut_data = lut_data | ({4{key == LUT[n][PAIR_W-1:4]}} & LUT[n][3:0]);
      hit      = hit | (key == LUT[n][PAIR_W-1:4]);
    end
  end

  assign alu_op = hit ? rv_exec_pkg::alu_op_e'(lut_data) : rv_exec_pkg::ALU_ILLEGAL;

  // rs1 and rd sit at the same bits in both views
  assign rs1_full = instr.r.rs1;
  assign rd_full  = instr.r.rd;

  // rs2 only matters for OP
  assign idx_bad = (rs1_full >= REG_COUNT) || (rd_full >= REG_COUNT) ||
                   (!use_imm && (instr.r.rs2 >= REG_COUNT));

  assign rs1_addr = rs1_full[IDX_W-1:0];
  assign rs2_addr = instr.r.rs2[IDX_W-1:0];
  assign rd_addr  = rd_full[IDX_W-1:0];
  assign imm      = {{20{instr.i.imm12[11]}}, instr.i.imm12};

  assign illegal = (alu_op == rv_exec_pkg::ALU_ILLEGAL) | idx_bad;
  assign wr_req  = issue & ~illegal;

endmodule

`default_nettype wire

//--- hw/rv_regfile.sv
// REG_COUNT words, power of two; x0 reads zero and ignores writes, whole array cleared on reset
`timescale 1ns/1ps
`default_nettype none

module rv_regfile #(
  parameter int REG_COUNT = 32
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [$clog2(REG_COUNT)-1:0]    rs1_addr,
  output rv_exec_pkg::word_t              rs1_data,
  input  logic [$clog2(REG_COUNT)-1:0]    rs2_addr,
  output rv_exec_pkg::word_t              rs2_data,
  input  logic [$clog2(REG_COUNT)-1:0]    dbg_addr,
  output rv_exec_pkg::word_t              dbg_data,
  input  logic                            wen,
  input  logic [$clog2(REG_COUNT)-1:0]    waddr,
  input  rv_exec_pkg::word_t              wdata
);

  rv_exec_pkg::word_t rf [REG_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int n = 0; n < REG_COUNT; n++) begin
        rf[n] <= '0;
      end
    end else if (wen && waddr != '0) begin
      rf[waddr] <= wdata;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : rf[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : rf[rs2_addr];
  // Host debug read
  assign dbg_data = (dbg_addr == '0) ? '0 : rf[dbg_addr];

  a_x0_stays_zero: assert property (
    @(posedge clk) disable iff (rst) (wen && waddr == '0) |=> (rf[0] == '0)
  );

endmodule

`default_nettype wire

//--- hw/rv_alu_wb.sv
// Combinational ALU and writeback; shift amount is the low five bits of the second operand
`timescale 1ns/1ps
`default_nettype none

module rv_alu_wb #(
  parameter int REG_COUNT = 32
) (
  input  rv_exec_pkg::word_t              rs1_data,
  input  rv_exec_pkg::word_t              rs2_data,
  input  rv_exec_pkg::word_t              imm,
  input  logic                            use_imm,
  input  rv_exec_pkg::alu_op_e            alu_op,
  input  logic [$clog2(REG_COUNT)-1:0]    rd_addr,
  input  logic                            wr_req,
  output logic                            wen,
  output logic [$clog2(REG_COUNT)-1:0]    waddr,
  output rv_exec_pkg::word_t              wdata
);

  rv_exec_pkg::word_t op_a;
  rv_exec_pkg::word_t op_b;
  rv_exec_pkg::word_t result;
  logic [4:0]         shamt;

  assign op_a  = rs1_data;
  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      rv_exec_pkg::ALU_ADD:  result = op_a + op_b;
      rv_exec_pkg::ALU_SUB:  result = op_a - op_b;
      rv_exec_pkg::ALU_SLL:  result = op_a << shamt;
      rv_exec_pkg::ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_exec_pkg::ALU_SLTU: result = {31'b0, op_a < op_b};
      rv_exec_pkg::ALU_XOR:  result = op_a ^ op_b;
      rv_exec_pkg::ALU_SRL:  result = op_a >> shamt;
      // Arithmetic shift keeps the sign bit
      rv_exec_pkg::ALU_SRA:  result = $signed(op_a) >>> shamt;
      rv_exec_pkg::ALU_OR:   result = op_a | op_b;
      rv_exec_pkg::ALU_AND:  result = op_a & op_b;
      default:               result = '0;
    endcase
  end

  assign wen   = wr_req;
  assign waddr = rd_addr;
  assign wdata = result;

  // Decoder must never request a write for an unmatched encoding
  a_no_illegal_write: assert final (!(wen && alu_op == rv_exec_pkg::ALU_ILLEGAL));

endmodule

`default_nettype wire

//--- hw/rv_exec_top.sv
// RV32 OP/OP-IMM execution slice behind APB3; set REG_COUNT to 16 for an RV32E build
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top #(
  parameter int REG_COUNT = 32
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [rv_exec_pkg::APB_ADDR_W-1:0]  paddr,
  input  rv_exec_pkg::word_t                  pwdata,
  output rv_exec_pkg::word_t                  prdata,
  output logic                                pready,
  output logic                                pslverr
);

  localparam int IDX_W = $clog2(REG_COUNT);

  rv_exec_pkg::rv_instr_t  instr;
  logic                    issue;
  logic                    illegal;
  logic [IDX_W-1:0]        dbg_addr;
  rv_exec_pkg::word_t      dbg_data;
  logic [IDX_W-1:0]        rs1_addr;
  logic [IDX_W-1:0]        rs2_addr;
  logic [IDX_W-1:0]        rd_addr;
  rv_exec_pkg::word_t      imm;
  logic                    use_imm;
  rv_exec_pkg::alu_op_e    alu_op;
  logic                    wr_req;
  rv_exec_pkg::word_t      rs1_data;
  rv_exec_pkg::word_t      rs2_data;
  logic                    wen;
  logic [IDX_W-1:0]        waddr;
  rv_exec_pkg::word_t      wdata;

  rv_apb_port #(.REG_COUNT(REG_COUNT)) i_rv_apb_port (
    .clk      (clk),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .instr    (instr),
    .issue    (issue),
    .illegal  (illegal),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

  rv_decoder #(.REG_COUNT(REG_COUNT)) i_rv_decoder (
    .instr    (instr),
    .issue    (issue),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .imm      (imm),
    .use_imm  (use_imm),
    .alu_op   (alu_op),
    .wr_req   (wr_req),
    .illegal  (illegal)
  );

  rv_regfile #(.REG_COUNT(REG_COUNT)) i_rv_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs1_data (rs1_data),
    .rs2_addr (rs2_addr),
    .rs2_data (rs2_data),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data),
    .wen      (wen),
    .waddr    (waddr),
    .wdata    (wdata)
  );

  rv_alu_wb #(.REG_COUNT(REG_COUNT)) i_rv_alu_wb (
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .use_imm  (use_imm),
    .alu_op   (alu_op),
    .rd_addr  (rd_addr),
    .wr_req   (wr_req),
    .wen      (wen),
    .waddr    (waddr),
    .wdata    (wdata)
  );

endmodule

`default_nettype wire

//--- tests/tb_rv_exec.sv
// Directed testbench for rv_exec_top with REG_COUNT 32; APB transfers have no wait states
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec;

  localparam int N_XFER    = 332;
  localparam int CYC_LIMIT = 16 + 3 * N_XFER + 200;

  logic                               clk;
  logic                               rst;
  logic                               psel;
  logic                               penable;
  logic                               pwrite;
  logic [rv_exec_pkg::APB_ADDR_W-1:0] paddr;
  rv_exec_pkg::word_t                 pwdata;
  rv_exec_pkg::word_t                 prdata;
  logic                               pready;
  logic                               pslverr;

  rv_exec_pkg::word_t ref_rf [32];
  int                 data_errs;
  int                 resp_errs;
  int                 cycles;
  int unsigned        rnd;

  rv_exec_top #(.REG_COUNT(32)) i_rv_exec_top (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYC_LIMIT) begin
      $display("Run hung: cycle limit of %0d reached before the tests ended", CYC_LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic rv_exec_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
    enc_r = {f7, rs2, rs1, f3, rd, rv_exec_pkg::OPC_OP};
  endfunction

  function automatic rv_exec_pkg::word_t enc_i(input logic [11:0] imm12, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
    enc_i = {imm12, rs1, f3, rd, rv_exec_pkg::OPC_OP_IMM};
  endfunction

  // RV32I result rules per funct3; alt selects SUB or SRA
  function automatic rv_exec_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                                 input rv_exec_pkg::word_t a,
                                                 input rv_exec_pkg::word_t b);
    logic [4:0]         sh;
    rv_exec_pkg::word_t fill;
    rv_exec_pkg::word_t res;
    sh   = b[4:0];
    fill = ~(32'hffff_ffff >> sh);
    case (f3)
      3'd0: res = alt ? a - b : a + b;
      3'd1: res = a << sh;
      3'd2: res = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      3'd3: res = {31'b0, a < b};
      3'd4: res = a ^ b;
      3'd5: res = (alt && a[31]) ? ((a >> sh) | fill) : (a >> sh);
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    alu_ref = res;
  endfunction

  task automatic check_word(input rv_exec_pkg::word_t exp, input rv_exec_pkg::word_t got,
                            input string what);
    if (got !== exp) begin
      data_errs++;
      $display("ERROR @%0t: %s expected %h got %h", $time, what, exp, got);
    end
  endtask

  task automatic check_err(input logic exp, input logic got, input string what);
    if (got !== exp) begin
      resp_errs++;
      $display("ERROR @%0t: %s pslverr expected %b got %b", $time, what, exp, got);
    end
  endtask

  task automatic check_ready(input logic exp, input logic got, input string what);
    if (got !== exp) begin
      resp_errs++;
      $display("ERROR @%0t: %s pready expected %b got %b", $time, what, exp, got);
    end
  endtask

  task automatic apb_transfer(input logic wr, input logic [rv_exec_pkg::APB_ADDR_W-1:0] addr,
                              input rv_exec_pkg::word_t data,
                              output rv_exec_pkg::word_t rdata, output logic err);
    @(posedge clk);
    #2;
    psel   = 1'b1;
    pwrite = wr;
    paddr  = addr;
    pwdata = data;
    @(posedge clk);
    #2;
    penable = 1'b1;
    // No wait states, so the access phase always completes here
    check_ready(1'b1, pready, $sformatf("access phase at %h", addr));
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [rv_exec_pkg::APB_ADDR_W-1:0] addr,
                           input rv_exec_pkg::word_t data,
                           output rv_exec_pkg::word_t rdata, output logic err);
    apb_transfer(1'b1, addr, data, rdata, err);
  endtask

  task automatic apb_read(input logic [rv_exec_pkg::APB_ADDR_W-1:0] addr,
                          output rv_exec_pkg::word_t rdata, output logic err);
    apb_transfer(1'b0, addr, '0, rdata, err);
  endtask

  task automatic issue_instr(input rv_exec_pkg::word_t ins, input logic exp_err);
    rv_exec_pkg::word_t rdata;
    logic               err;
    apb_write(rv_exec_pkg::ADDR_ISSUE, ins, rdata, err);
    check_err(exp_err, err, $sformatf("issue %h", ins));
  endtask

  task automatic check_reg(input int idx);
    rv_exec_pkg::word_t rdata;
    logic               err;
    apb_read(rv_exec_pkg::ADDR_REG_BASE + 12'(idx * 4), rdata, err);
    check_err(1'b0, err, $sformatf("read x%0d", idx));
    check_word(ref_rf[idx], rdata, $sformatf("x%0d", idx));
  endtask

  task automatic exec_imm(input logic [2:0] f3, input int rd, input int rs1,
                          input logic [11:0] imm12, input logic check);
    rv_exec_pkg::word_t exp;
    exp = alu_ref(f3, (f3 == 3'd5) && imm12[10], ref_rf[rs1], {{20{imm12[11]}}, imm12});
    issue_instr(enc_i(imm12, 5'(rs1), f3, 5'(rd)), 1'b0);
    if (rd != 0) ref_rf[rd] = exp;
    if (check) check_reg(rd);
  endtask

  task automatic exec_reg(input logic [6:0] f7, input logic [2:0] f3, input int rd,
                          input int rs1, input int rs2, input logic check);
    rv_exec_pkg::word_t exp;
    exp = alu_ref(f3, f7[5], ref_rf[rs1], ref_rf[rs2]);
    issue_instr(enc_r(f7, 5'(rs2), 5'(rs1), f3, 5'(rd)), 1'b0);
    if (rd != 0) ref_rf[rd] = exp;
    if (check) check_reg(rd);
  endtask

  task automatic test_reset_values();
    for (int n = 0; n < 32; n++) check_reg(n);
  endtask

  task automatic test_op_imm();
    exec_imm(3'd0, 7, 0, 12'haab, 1'b1);
    exec_imm(3'd0, 8, 0, 12'h7ff, 1'b1);
    exec_imm(3'd0, 9, 7, 12'd100, 1'b1);
    exec_imm(3'd2, 9, 7, 12'hfff, 1'b1);
    exec_imm(3'd3, 9, 7, 12'hfff, 1'b1);
    exec_imm(3'd4, 9, 8, 12'h8f0, 1'b1);
    exec_imm(3'd6, 9, 7, 12'h00f, 1'b1);
    exec_imm(3'd7, 9, 7, 12'hf0f, 1'b1);
    exec_imm(3'd1, 9, 8, 12'h01f, 1'b1);
    exec_imm(3'd5, 9, 7, 12'h004, 1'b1);
    exec_imm(3'd5, 9, 7, 12'h404, 1'b1);
  endtask

  task automatic test_op_reg();
    exec_imm(3'd0, 1, 0, 12'hff9, 1'b1);
    exec_imm(3'd0, 2, 0, 12'd5, 1'b1);
    exec_imm(3'd0, 3, 0, 12'hfff, 1'b1);
    exec_imm(3'd0, 4, 0, 12'd3, 1'b1);
    exec_reg(7'h00, 3'd0, 10, 1, 2, 1'b1);
    exec_reg(7'h20, 3'd0, 11, 2, 1, 1'b1);
    exec_reg(7'h00, 3'd1, 12, 1, 4, 1'b1);
    exec_reg(7'h00, 3'd2, 13, 1, 2, 1'b1);
    exec_reg(7'h00, 3'd3, 14, 1, 2, 1'b1);
    exec_reg(7'h00, 3'd2, 15, 2, 1, 1'b1);
    exec_reg(7'h00, 3'd3, 16, 2, 1, 1'b1);
    exec_reg(7'h00, 3'd4, 17, 1, 3, 1'b1);
    // Shift by x1 uses only its low five bits
    exec_reg(7'h00, 3'd5, 18, 3, 1, 1'b1);
    exec_reg(7'h20, 3'd5, 19, 1, 4, 1'b1);
    exec_reg(7'h00, 3'd6, 20, 1, 2, 1'b1);
    exec_reg(7'h00, 3'd7, 21, 1, 2, 1'b1);
  endtask

  task automatic test_x0_dest();
    exec_imm(3'd0, 0, 1, 12'd123, 1'b0);
    exec_reg(7'h00, 3'd0, 0, 1, 2, 1'b1);
  endtask

  task automatic test_errors();
    rv_exec_pkg::word_t rdata;
    logic               err;
    // Nonzero x5 so a stray write of a zero result shows up
    exec_imm(3'd0, 5, 0, 12'h5a5, 1'b1);
    issue_instr({12'h010, 5'd1, 3'd2, 5'd5, 7'b0000011}, 1'b1);
    issue_instr(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd5), 1'b1);
    issue_instr(enc_i(12'h801, 5'd1, 3'd1, 5'd5), 1'b1);
    apb_write(12'h004, enc_i(12'd55, 5'd0, 3'd0, 5'd6), rdata, err);
    check_err(1'b1, err, "write to non-issue address");
    apb_read(12'h180, rdata, err);
    check_err(1'b1, err, "read past register window");
    check_word('0, rdata, "prdata past register window");
    apb_read(12'h102, rdata, err);
    check_err(1'b1, err, "misaligned register read");
    check_word('0, rdata, "prdata misaligned read");
    apb_read(rv_exec_pkg::ADDR_ISSUE, rdata, err);
    check_err(1'b1, err, "read of issue address");
    check_reg(5);
    check_reg(6);
  endtask

  task automatic test_random();
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    int          rd;
    int          rs1;
    int          rs2;
    for (int n = 0; n < 200; n++) begin
      f3  = 3'($urandom);
      rd  = $urandom % 32;
      rs1 = $urandom % 32;
      rs2 = $urandom % 32;
      if ($urandom % 2) begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2)) ? 7'h20 : 7'h00;
        exec_reg(f7, f3, rd, rs1, rs2, 1'b0);
      end else begin
        imm12 = 12'($urandom);
        if (f3 == 3'd1) imm12[11:5] = 7'h00;
        if (f3 == 3'd5) imm12[11:5] = ($urandom % 2) ? 7'h20 : 7'h00;
        exec_imm(f3, rd, rs1, imm12, 1'b0);
      end
    end
    for (int n = 0; n < 32; n++) check_reg(n);
  endtask

  initial begin
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    rst       = 1'b1;
    data_errs = 0;
    resp_errs = 0;
    cycles    = 0;
    rnd       = $urandom(32'hfdba_9b77);
    for (int n = 0; n < 32; n++) ref_rf[n] = '0;
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;

    test_reset_values();
    test_op_imm();
    test_op_reg();
    test_x0_dest();
    test_errors();
    test_random();

    $display("Summary: %0d data errors, %0d response errors", data_errs, resp_errs);
    if (data_errs == 0 && resp_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_exec.f
hw/rv_exec_pkg.sv
hw/rv_apb_port.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu_wb.sv
hw/rv_exec_top.sv
tests/tb_rv_exec.sv

//--- Bender.yml
package:
  name: rv_exec

sources:
  - hw/rv_exec_pkg.sv
  - hw/rv_apb_port.sv
  - hw/rv_decoder.sv
  - hw/rv_regfile.sv
  - hw/rv_alu_wb.sv
  - hw/rv_exec_top.sv
  - target: test
    files:
      - tests/tb_rv_exec.sv
